// ==== sim.f ====
+incdir+common
common/decoder_pkg.sv
common/stage_bus_if.sv
hdl/link_fifo.sv
stage_controller/stage_controller.sv
stage_controller/stage_monitor.sv
hdl/root_streamer.sv
hdl/decoder_stage_follower.sv
bench/decoder_stage_checker.sv
bench/tb_decoder_stage_follower.sv

// ==== bench/tb_decoder_stage_follower.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module tb_decoder_stage_follower import decoder_pkg::*; ();

    typedef struct packed {
        logic [`TAG_WIDTH-1:0] tag;
        stage_t                stage;
        iter_count_t           iters;
    } step_t;

    localparam int STEPS        = 13;
    localparam int STREAM_WORDS = `PU_COUNT + 1;

    logic                     clk;
    logic                     reset;
    logic                     new_round_start;
    pu_addr_t [`PU_COUNT-1:0] roots;
    logic [`PU_COUNT-1:0]     is_odd_cardinalities;
    logic [`PU_COUNT-1:0]     is_touching_boundaries;
    stage_t                   stage;
    logic                     result_valid;
    logic                     deadlock;
    iter_count_t              iteration_counter;
    cycle_count_t             cycle_counter;
    hub_word_t                sc_fifo_in_data;
    logic                     sc_fifo_in_valid;
    logic                     sc_fifo_in_ready;
    hub_word_t                sc_fifo_out_data;
    logic                     sc_fifo_out_valid;
    logic                     sc_fifo_out_ready;

    step_t steps [STEPS];
    int    checks = 0;
    int    errors = 0;

    decoder_stage_follower i_decoder_stage_follower (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_stage(input stage_t actual, input stage_t expected, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic check_count(input iter_count_t actual, input iter_count_t expected,
                               input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic check_cycles(input cycle_count_t actual, input cycle_count_t expected,
                                input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic check_word(input hub_word_t actual, input hub_word_t expected,
                              input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // one edge pushes the word, one more and the controller has consumed it
    task automatic push_command(input logic [`TAG_WIDTH-1:0] tag);
        int cycles;
        cycles = 0;
        sc_fifo_in_data  = hub_word_t'(tag);
        sc_fifo_in_valid = 1'b1;
        while (!sc_fifo_in_ready) begin
            if (cycles == 100) begin
                give_up("sc_fifo_in_ready");
            end
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        sc_fifo_in_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic await_stage(input stage_t target);
        int cycles;
        cycles = 0;
        while (stage !== target && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        check_stage(stage, target, "stage");
    endtask

    task automatic randomize_units();
        logic [31:0] odd_bits;
        logic [31:0] boundary_bits;
        for (int i = 0; i < `PU_COUNT; i++) begin
            roots[i] = pu_addr_t'($urandom);
        end
        odd_bits               = $urandom;
        boundary_bits          = $urandom;
        is_odd_cardinalities   = odd_bits[`PU_COUNT-1:0];
        is_touching_boundaries = boundary_bits[`PU_COUNT-1:0];
    endtask

    // word layout: boundary flag, odd flag, root, tag
    function automatic hub_word_t expected_word(input int index);
        if (index < `PU_COUNT) begin
            return {is_touching_boundaries[index], is_odd_cardinalities[index],
                    roots[index], `MSG_ROOT};
        end
        return hub_word_t'(`MSG_END);
    endfunction

    task automatic collect_stream(input bit throttle);
        int received;
        int cycles;
        int stretch;
        received = 0;
        cycles   = 0;
        stretch  = 0;
        sc_fifo_out_ready = 1'b1;
        while (received < STREAM_WORDS) begin
            if (cycles == 2000) begin
                give_up("result stream");
            end
            // alternate ready stretches, low ones long enough to fill the FIFO
            if (throttle && stretch == 0) begin
                sc_fifo_out_ready = !sc_fifo_out_ready;
                stretch = sc_fifo_out_ready ? $urandom_range(4, 1) : $urandom_range(24, 2);
            end
            if (sc_fifo_out_ready && sc_fifo_out_valid) begin
                check_word(sc_fifo_out_data, expected_word(received), "sc_fifo_out_data");
                received++;
            end
            @(negedge clk);
            cycles++;
            if (stretch > 0) begin
                stretch--;
            end
        end
        sc_fifo_out_ready = 1'b1;
    endtask

    task automatic run_result_round(input bit throttle);
        cycle_count_t frozen;
        randomize_units();
        push_command(`CMD_ADVANCE);
        await_stage(STAGE_SPREAD_CLUSTER);
        push_command(`CMD_ADVANCE);
        await_stage(STAGE_SYNC_IS_ODD_CLUSTER);
        push_command(`CMD_CONVERGED);
        collect_stream(throttle);
        await_stage(STAGE_IDLE);
        check_flag(result_valid, 1'b1, "result_valid");
        frozen = cycle_counter;
        repeat (8) @(negedge clk);
        check_cycles(cycle_counter, frozen, "cycle_counter");
        // nothing left over or repeated
        check_flag(sc_fifo_out_valid, 1'b0, "sc_fifo_out_valid");
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h30cd));
        reset                  = 1'b1;
        new_round_start        = 1'b0;
        roots                  = '0;
        is_odd_cardinalities   = '0;
        is_touching_boundaries = '0;
        sc_fifo_in_data        = '0;
        sc_fifo_in_valid       = 1'b0;
        sc_fifo_out_ready      = 1'b1;

        // tag, stage after acceptance, iterations so far
        steps[0]  = '{`CMD_ADVANCE, STAGE_SPREAD_CLUSTER, 8'd0};
        steps[1]  = '{3'd7, STAGE_SPREAD_CLUSTER, 8'd0};
        steps[2]  = '{`CMD_ADVANCE, STAGE_SYNC_IS_ODD_CLUSTER, 8'd0};
        steps[3]  = '{`CMD_ADVANCE, STAGE_GROW_BOUNDARY, 8'd1};
        steps[4]  = '{3'd0, STAGE_GROW_BOUNDARY, 8'd1};
        steps[5]  = '{`CMD_ADVANCE, STAGE_SPREAD_CLUSTER, 8'd1};
        steps[6]  = '{`CMD_ADVANCE, STAGE_SYNC_IS_ODD_CLUSTER, 8'd1};
        steps[7]  = '{`CMD_ADVANCE, STAGE_GROW_BOUNDARY, 8'd2};
        steps[8]  = '{`CMD_ABORT, STAGE_IDLE, 8'd2};
        steps[9]  = '{`CMD_CONVERGED, STAGE_IDLE, 8'd2};
        steps[10] = '{`CMD_ADVANCE, STAGE_SPREAD_CLUSTER, 8'd0};
        steps[11] = '{`CMD_ADVANCE, STAGE_SYNC_IS_ODD_CLUSTER, 8'd0};
        steps[12] = '{`CMD_ABORT, STAGE_IDLE, 8'd0};

        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_stage(stage, STAGE_IDLE, "stage");
        check_flag(result_valid, 1'b0, "result_valid");
        check_flag(deadlock, 1'b0, "deadlock");
        check_flag(sc_fifo_out_valid, 1'b0, "sc_fifo_out_valid");
        check_flag(sc_fifo_in_ready, 1'b1, "sc_fifo_in_ready");
        check_count(iteration_counter, '0, "iteration_counter");
        // one edge counted since reset released
        check_cycles(cycle_counter, cycle_count_t'(1), "cycle_counter");

        for (int i = 0; i < STEPS; i++) begin
            push_command(steps[i].tag);
            await_stage(steps[i].stage);
            check_count(iteration_counter, steps[i].iters, "iteration_counter");
            check_flag(sc_fifo_out_valid, 1'b0, "sc_fifo_out_valid");
        end

        run_result_round(1'b0);
        run_result_round(1'b1);

        // park in spread until the stall limit trips
        push_command(`CMD_ADVANCE);
        await_stage(STAGE_SPREAD_CLUSTER);
        check_flag(deadlock, 1'b0, "deadlock");
        cycles = 0;
        while (!deadlock) begin
            if (cycles == 400) begin
                give_up("deadlock");
            end
            @(negedge clk);
            cycles++;
        end
        // stall count passes the limit after threshold plus one edges, flag one edge later
        checks++;
        if (cycles != `DEADLOCK_THRESHOLD + 2) begin
            errors++;
            $display("ERROR deadlock: raised after %0h cycles in spread, expected %0h",
                     cycles, `DEADLOCK_THRESHOLD + 2);
        end
        new_round_start = 1'b1;
        @(negedge clk);
        new_round_start = 1'b0;
        check_flag(deadlock, 1'b0, "deadlock");
        push_command(`CMD_ABORT);
        await_stage(STAGE_IDLE);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/decoder_stage_checker.sv ====
`timescale 1ns/1ps

module decoder_stage_checker import decoder_pkg::*; (
    input logic        clk,
    input logic        reset,
    input stage_t      stage,
    input iter_count_t iteration_counter,
    input logic        result_valid,
    input logic        deadlock,
    input logic        sc_fifo_out_valid,
    input logic        out_push
);

    // loading is a single cycle
    assert property (@(posedge clk) disable iff (reset)
        stage == STAGE_MEASUREMENT_LOADING |=> stage == STAGE_SPREAD_CLUSTER)
        else $error("loading was not followed by spread");

    assert property (@(posedge clk)
        $fell(reset) |-> stage == STAGE_IDLE && !result_valid && !deadlock &&
                         !sc_fifo_out_valid)
        else $error("stage or flags not cleared by reset");

    // hold, step by one, or clear on a new round
    assert property (@(posedge clk) disable iff (reset)
        iteration_counter == $past(iteration_counter) ||
        iteration_counter == iter_count_t'($past(iteration_counter) + 1'b1) ||
        iteration_counter == '0)
        else $error("iteration_counter changed by more than one");

    // an empty out_fifo only fills through a push by the streamer
    assert property (@(posedge clk) disable iff (reset)
        $rose(sc_fifo_out_valid) |-> $past(out_push))
        else $error("sc_fifo_out_valid rose without a word pushed into out_fifo");

endmodule

bind decoder_stage_follower decoder_stage_checker i_decoder_stage_checker (
    .clk               (clk),
    .reset             (reset),
    .stage             (stage),
    .iteration_counter (iteration_counter),
    .result_valid      (result_valid),
    .deadlock          (deadlock),
    .sc_fifo_out_valid (sc_fifo_out_valid),
    .out_push          (out_push)
);

// ==== hdl/decoder_stage_follower.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module decoder_stage_follower import decoder_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        new_round_start,
    input  pu_addr_t [`PU_COUNT-1:0]    roots,
    input  logic [`PU_COUNT-1:0]        is_odd_cardinalities,
    input  logic [`PU_COUNT-1:0]        is_touching_boundaries,
    output stage_t                      stage,
    output logic                        result_valid,
    output logic                        deadlock,
    output iter_count_t                 iteration_counter,
    output cycle_count_t                cycle_counter,
    input  hub_word_t                   sc_fifo_in_data,
    input  logic                        sc_fifo_in_valid,
    output logic                        sc_fifo_in_ready,
    output hub_word_t                   sc_fifo_out_data,
    output logic                        sc_fifo_out_valid,
    input  logic                        sc_fifo_out_ready
);

    // hub to controller
    hub_word_t cmd_word;
    logic      cmd_empty;
    logic      cmd_pop;
    logic      in_full;

    // streamer to hub
    hub_word_t out_word;
    logic      out_push;
    logic      out_full;
    logic      out_empty;

    stage_bus_if stage_bus ();

    assign sc_fifo_in_ready  = !in_full;
    assign sc_fifo_out_valid = !out_empty;
    assign stage             = stage_bus.stage;

    link_fifo #(
        .DEPTH (`LINK_FIFO_DEPTH),
        .WIDTH (`HUB_WORD_WIDTH)
    ) in_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (sc_fifo_in_valid),
        .din   (sc_fifo_in_data),
        .full  (in_full),
        .rd_en (cmd_pop),
        .dout  (cmd_word),
        .empty (cmd_empty)
    );

    link_fifo #(
        .DEPTH (`LINK_FIFO_DEPTH),
        .WIDTH (`HUB_WORD_WIDTH)
    ) out_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (out_push),
        .din   (out_word),
        .full  (out_full),
        .rd_en (sc_fifo_out_ready),
        .dout  (sc_fifo_out_data),
        .empty (out_empty)
    );

    stage_controller i_stage_controller (
        .clk       (clk),
        .reset     (reset),
        .cmd_word  (cmd_word),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .bus       (stage_bus.ctrl)
    );

    stage_monitor i_stage_monitor (
        .clk               (clk),
        .reset             (reset),
        .new_round_start   (new_round_start),
        .bus               (stage_bus.monitor),
        .iteration_counter (iteration_counter),
        .cycle_counter     (cycle_counter),
        .result_valid      (result_valid),
        .deadlock          (deadlock)
    );

    root_streamer i_root_streamer (
        .clk                    (clk),
        .reset                  (reset),
        .bus                    (stage_bus.streamer),
        .roots                  (roots),
        .is_odd_cardinalities   (is_odd_cardinalities),
        .is_touching_boundaries (is_touching_boundaries),
        .out_full               (out_full),
        .out_push               (out_push),
        .out_word               (out_word)
    );

endmodule

// ==== hdl/root_streamer.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module root_streamer import decoder_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    stage_bus_if.streamer               bus,
    input  pu_addr_t [`PU_COUNT-1:0]    roots,
    input  logic [`PU_COUNT-1:0]        is_odd_cardinalities,
    input  logic [`PU_COUNT-1:0]        is_touching_boundaries,
    input  logic                        out_full,
    output logic                        out_push,
    output hub_word_t                   out_word
);

    // one slot per unit plus the end marker
    localparam int INDEX_WIDTH = $clog2(`PU_COUNT + 1);

    logic [INDEX_WIDTH-1:0] unit_index;
    logic                   end_slot;

    assign end_slot = (unit_index == INDEX_WIDTH'(`PU_COUNT));

    // full holds the index, so no word is skipped or repeated
    assign out_push        = (bus.stage == STAGE_RESULT_CALCULATING) && !out_full;
    assign bus.result_done = out_push && end_slot;

    always_ff @(posedge clk) begin
        if (reset) begin
            unit_index <= '0;
        end else if (bus.stage != STAGE_RESULT_CALCULATING) begin
            unit_index <= '0;
        end else if (out_push) begin
            unit_index <= unit_index + 1'b1;
        end
    end

    // format the current slot
    always_comb begin
        out_word = '0;
        if (end_slot) begin
            out_word[`TAG_WIDTH-1:0] = `MSG_END;
        end else begin
            out_word[`TAG_WIDTH-1:0] = `MSG_ROOT;
            out_word[`TAG_WIDTH+`ADDRESS_WIDTH-1:`TAG_WIDTH] = roots[unit_index];
            out_word[`TAG_WIDTH+`ADDRESS_WIDTH] = is_odd_cardinalities[unit_index];
            out_word[`TAG_WIDTH+`ADDRESS_WIDTH+1] = is_touching_boundaries[unit_index];
        end
    end

endmodule

// ==== stage_controller/stage_monitor.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module stage_monitor import decoder_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            new_round_start,
    stage_bus_if.monitor    bus,
    output iter_count_t     iteration_counter,
    output cycle_count_t    cycle_counter,
    output logic            result_valid,
    output logic            deadlock
);

    // wide enough to reach one past the threshold
    localparam int STALL_WIDTH = $clog2(`DEADLOCK_THRESHOLD + 2);

    logic [STALL_WIDTH-1:0] stall_count;
    logic                   stalling;

    assign stalling = (bus.stage == STAGE_SPREAD_CLUSTER) ||
                      (bus.stage == STAGE_SYNC_IS_ODD_CLUSTER);

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter     <= '0;
            result_valid      <= 1'b0;
        end else begin
            if (bus.round_start) begin
                iteration_counter <= '0;
            end else if (bus.iteration_step) begin
                iteration_counter <= iteration_counter + 1'b1;
            end
            // round latency, frozen once the result is out
            if (bus.round_start) begin
                cycle_counter <= cycle_count_t'(1);
            end else if (!result_valid) begin
                cycle_counter <= cycle_counter + 1'b1;
            end
            if (bus.round_start) begin
                result_valid <= 1'b0;
            end else if (bus.result_done) begin
                result_valid <= 1'b1;
            end
        end
    end

    // stall counter saturates just past the limit
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_count <= '0;
            deadlock    <= 1'b0;
        end else begin
            if (!stalling) begin
                stall_count <= '0;
            end else if (stall_count <= STALL_WIDTH'(`DEADLOCK_THRESHOLD)) begin
                stall_count <= stall_count + 1'b1;
            end
            if (new_round_start) begin
                deadlock <= 1'b0;
            end else if (stall_count > STALL_WIDTH'(`DEADLOCK_THRESHOLD)) begin
                deadlock <= 1'b1;
            end
        end
    end

endmodule

// ==== stage_controller/stage_controller.sv ====
`timescale 1ns/1ps
`include "decoder_params.svh"

module stage_controller import decoder_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  hub_word_t cmd_word,
    input  logic      cmd_empty,
    output logic      cmd_pop,
    stage_bus_if.ctrl bus
);

    logic [`TAG_WIDTH-1:0] tag;
    logic                  cmd_valid;
    stage_t                stage_next;
    logic                  step_next;

    assign tag       = cmd_word[`TAG_WIDTH-1:0];
    assign cmd_valid = !cmd_empty;

    // decode the fifo head against the current stage
    always_comb begin
        stage_next = bus.stage;
        cmd_pop    = 1'b0;
        step_next  = 1'b0;
        case (bus.stage)
            STAGE_IDLE: begin
                // other tags are dropped here too
                cmd_pop = cmd_valid;
                if (cmd_valid && tag == `CMD_ADVANCE) begin
                    stage_next = STAGE_MEASUREMENT_LOADING;
                end
            end
            STAGE_MEASUREMENT_LOADING: begin
                // single cycle, head word waits for spread
                stage_next = STAGE_SPREAD_CLUSTER;
            end
            STAGE_SPREAD_CLUSTER: begin
                cmd_pop = cmd_valid;
                if (cmd_valid) begin
                    case (tag)
                        `CMD_ADVANCE: stage_next = STAGE_SYNC_IS_ODD_CLUSTER;
                        `CMD_ABORT:   stage_next = STAGE_IDLE;
                        default:      stage_next = bus.stage;
                    endcase
                end
            end
            STAGE_SYNC_IS_ODD_CLUSTER: begin
                cmd_pop = cmd_valid;
                if (cmd_valid) begin
                    case (tag)
                        `CMD_ADVANCE: begin
                            stage_next = STAGE_GROW_BOUNDARY;
                            step_next  = 1'b1;
                        end
                        `CMD_CONVERGED: stage_next = STAGE_RESULT_CALCULATING;
                        `CMD_ABORT:     stage_next = STAGE_IDLE;
                        default:        stage_next = bus.stage;
                    endcase
                end
            end
            STAGE_GROW_BOUNDARY: begin
                cmd_pop = cmd_valid;
                if (cmd_valid) begin
                    case (tag)
                        `CMD_ADVANCE: stage_next = STAGE_SPREAD_CLUSTER;
                        `CMD_ABORT:   stage_next = STAGE_IDLE;
                        default:      stage_next = bus.stage;
                    endcase
                end
            end
            STAGE_RESULT_CALCULATING: begin
                // commands queue up until the stream is out
                if (bus.result_done) begin
                    stage_next = STAGE_IDLE;
                end
            end
            default: begin
                stage_next = STAGE_IDLE;
            end
        endcase
    end

    assign bus.round_start    = (bus.stage == STAGE_MEASUREMENT_LOADING);
    assign bus.iteration_step = step_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.stage <= STAGE_IDLE;
        end else begin
            bus.stage <= stage_next;
        end
    end

endmodule

// ==== hdl/link_fifo.sv ====
`timescale 1ns/1ps

module link_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 11
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_write;
    logic                 do_read;

    assign full     = (count == (PTR_WIDTH + 1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // head word is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== common/stage_bus_if.sv ====
`timescale 1ns/1ps

interface stage_bus_if import decoder_pkg::*; ();

    // current decoding stage
    stage_t stage;
    // high for the single loading cycle
    logic   round_start;
    // sync to grow transition
    logic   iteration_step;
    // end marker has been pushed
    logic   result_done;

    modport ctrl (
        output stage,
        output round_start,
        output iteration_step,
        input  result_done
    );

    modport streamer (
        input  stage,
        output result_done
    );

    modport monitor (
        input stage,
        input round_start,
        input iteration_step,
        input result_done
    );

endinterface

// ==== common/decoder_pkg.sv ====
`include "decoder_params.svh"

package decoder_pkg;

    // decoding stages, encoding shared with the hub
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_SPREAD_CLUSTER      = 3'd1,
        STAGE_GROW_BOUNDARY       = 3'd2,
        STAGE_SYNC_IS_ODD_CLUSTER = 3'd3,
        STAGE_MEASUREMENT_LOADING = 3'd4,
        STAGE_RESULT_CALCULATING  = 3'd5
    } stage_t;

    // root address of one processing unit
    typedef logic [`ADDRESS_WIDTH-1:0] pu_addr_t;

    // link word layout, lsb first
    //   tag, root address, odd cardinality, touching boundary
    typedef logic [`HUB_WORD_WIDTH-1:0] hub_word_t;

    // round statistics
    typedef logic [`ITERATION_WIDTH-1:0] iter_count_t;
    typedef logic [`CYCLE_WIDTH-1:0] cycle_count_t;

endpackage

// ==== common/decoder_params.svh ====
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// surface code geometry
`define CODE_DISTANCE_X 3
`define CODE_DISTANCE_Z 3
`define MEASUREMENT_ROUNDS \
    ((`CODE_DISTANCE_X > `CODE_DISTANCE_Z) ? `CODE_DISTANCE_X : `CODE_DISTANCE_Z)
`define PU_COUNT (`CODE_DISTANCE_X * `CODE_DISTANCE_Z * `MEASUREMENT_ROUNDS)

// three 2-bit coordinate fields per unit address
`define ADDRESS_WIDTH 6
`define TAG_WIDTH 3
// tag, address, odd flag, boundary flag
`define HUB_WORD_WIDTH (`TAG_WIDTH + `ADDRESS_WIDTH + 2)

`define LINK_FIFO_DEPTH 16
`define DEADLOCK_THRESHOLD (`PU_COUNT * 10)
`define ITERATION_WIDTH 8
`define CYCLE_WIDTH 32

// hub message tags
`define CMD_ADVANCE 3'd1
`define CMD_CONVERGED 3'd2
`define CMD_ABORT 3'd3
`define MSG_END 3'd4
`define MSG_ROOT 3'd5

`endif
